/* hw/calc_pkg.sv */
// shared calculator types; key opcodes 0, 6 and 7 are unused and rejected by the bus port
package calc_pkg;

    // controller states, ENTRY_A is the reset state
    typedef enum logic [3:0] {
        ENTRY_A,
        SCALE_A,
        ADD_DIGIT_A,
        ENTRY_B,
        SCALE_B,
        ADD_DIGIT_B,
        EXECUTE,
        WAIT_EXEC,
        SHOW
    } calc_state_t;

    // operator key codes as written to REG_OP
    typedef enum logic [2:0] {
        OP_NEG = 3'd1,
        OP_ADD = 3'd2,
        OP_SUB = 3'd3,
        OP_MUL = 3'd4,
        OP_EQ  = 3'd5
    } key_op_t;

    // one key press, port to controller
    // op is only meaningful when is_digit is low
    typedef struct packed {
        logic    valid;
        logic    is_digit;
        logic [3:0] digit;
        key_op_t op;
    } key_cmd_t;

    // apb byte offsets
    localparam logic [3:0] REG_KEY    = 4'h0;
    localparam logic [3:0] REG_OP     = 4'h4;
    localparam logic [3:0] REG_STATUS = 4'h8;
    localparam logic [3:0] REG_RESULT = 4'hC;

endpackage

/* hw/sm_addsub.sv */
// sign-magnitude add/subtract, magnitude wraps modulo 2**(WIDTH-1), one start per two cycles
`timescale 1ns/1ps

module sm_addsub #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             start,
    input  logic             sub,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] out,
    output logic             finish
);

    localparam int MW = WIDTH - 1;

    logic          a_sign;
    logic          b_sign;
    logic [MW-1:0] a_mag;
    logic [MW-1:0] b_mag;
    logic [MW-1:0] mag;
    logic          sign;

    assign a_sign = a[WIDTH-1];
    // subtraction is addition of b with its sign flipped
    assign b_sign = b[WIDTH-1] ^ sub;
    assign a_mag  = a[MW-1:0];
    assign b_mag  = b[MW-1:0];

    always_comb begin
        if (a_sign == b_sign) begin
            mag  = a_mag + b_mag;
            sign = a_sign;
        end else if (a_mag >= b_mag) begin
            mag  = a_mag - b_mag;
            sign = a_sign;
        end else begin
            mag  = b_mag - a_mag;
            sign = b_sign;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            out    <= '0;
            finish <= 1'b0;
        end else begin
            finish <= start;
            if (start) begin
                // zero always leaves as positive
                out <= {sign & (|mag), mag};
            end
        end
    end

    // the controller must not restart the unit while a result is being handed back
    a_start_idle: assert property (@(posedge clk) disable iff (!nRST) start |-> !finish);

endmodule

/* hw/seq_multiplier.sv */
// shift-add sign-magnitude multiply, keeps low WIDTH-1 product bits, needs WIDTH >= 4
`timescale 1ns/1ps

module seq_multiplier #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             start,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] out,
    output logic             finish
);

    localparam int MW = WIDTH - 1;
    localparam int CW = $clog2(WIDTH);

    logic          running;
    logic [CW-1:0] bit_cnt;
    logic [MW-1:0] mcand;
    logic [MW-1:0] mplier;
    logic [MW-1:0] acc;
    logic [MW-1:0] acc_next;
    logic          sign;

    // one multiplier bit per cycle, upper product bits fall off
    assign acc_next = acc + (mplier[0] ? mcand : '0);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            bit_cnt <= '0;
            finish  <= 1'b0;
            out     <= '0;
        end else begin
            finish <= 1'b0;
            if (start && !running) begin
                // bit 0 is consumed on the start edge
                running <= 1'b1;
                bit_cnt <= CW'(1);
            end else if (running) begin
                bit_cnt <= bit_cnt + CW'(1);
                if (bit_cnt == CW'(MW - 1)) begin
                    running <= 1'b0;
                    finish  <= 1'b1;
                    out     <= {sign & (|acc_next), acc_next};
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start && !running) begin
            acc    <= b[0] ? a[MW-1:0] : '0;
            mcand  <= a[MW-1:0] << 1;
            mplier <= b[MW-1:0] >> 1;
            sign   <= a[WIDTH-1] ^ b[WIDTH-1];
        end else if (running) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!nRST) start |-> !running);

    // fixed latency, the controller's digit timing depends on it
    a_latency: assert property (@(posedge clk) disable iff (!nRST)
        start && !running |-> ##(WIDTH-1) finish);

endmodule

/* hw/calc_controller.sv */
// keypad entry FSM; one operator per calculation, operands reset to +0 after each result
`timescale 1ns/1ps

module calc_controller #(
    parameter int WIDTH = 16
) (
    input  logic               clk,
    input  logic               nRST,
    input  calc_pkg::key_cmd_t cmd,
    output logic               cmd_ready,
    output logic               busy,
    output logic               done,
    output logic [WIDTH-1:0]   result,
    output logic               as_start,
    output logic               as_sub,
    output logic [WIDTH-1:0]   as_a,
    output logic [WIDTH-1:0]   as_b,
    input  logic [WIDTH-1:0]   as_out,
    input  logic               as_finish,
    output logic               mul_start,
    output logic [WIDTH-1:0]   mul_a,
    output logic [WIDTH-1:0]   mul_b,
    input  logic [WIDTH-1:0]   mul_out,
    input  logic               mul_finish
);

    localparam int MW = WIDTH - 1;
    localparam logic [WIDTH-1:0] TEN = WIDTH'(10);

    calc_pkg::calc_state_t state;
    calc_pkg::key_op_t     oper;
    logic [WIDTH-1:0]      op_a;
    logic [WIDTH-1:0]      op_b;
    logic [3:0]            digit_q;
    logic                  accept;
    logic                  in_a;
    logic                  exec_mul;
    logic                  unit_finish;

    // build a value and fold negative zero to positive
    function automatic logic [WIDTH-1:0] fold(input logic s, input logic [MW-1:0] m);
        return {s & (|m), m};
    endfunction

    assign cmd_ready   = (state == calc_pkg::ENTRY_A) || (state == calc_pkg::ENTRY_B);
    assign busy        = !cmd_ready;
    assign accept      = cmd.valid && cmd_ready;
    assign in_a        = (state == calc_pkg::ENTRY_A);
    assign exec_mul    = (oper == calc_pkg::OP_MUL);
    assign unit_finish = exec_mul ? mul_finish : as_finish;

    assign as_a   = op_a;
    assign as_b   = op_b;
    assign as_sub = (oper == calc_pkg::OP_SUB);

    // multiplier is shared: times ten while scaling, op_a * op_b on execute
    always_comb begin
        mul_a = op_a;
        mul_b = op_b;
        if (state == calc_pkg::SCALE_A) begin
            mul_b = TEN;
        end else if (state == calc_pkg::SCALE_B) begin
            mul_a = op_b;
            mul_b = TEN;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && cmd.is_digit) begin
            digit_q <= cmd.digit;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= calc_pkg::ENTRY_A;
            oper      <= calc_pkg::OP_ADD;
            op_a      <= '0;
            op_b      <= '0;
            done      <= 1'b0;
            result    <= '0;
            as_start  <= 1'b0;
            mul_start <= 1'b0;
        end else begin
            as_start  <= 1'b0;
            mul_start <= 1'b0;
            if (accept) begin
                done <= 1'b0;
            end
            case (state)
                calc_pkg::ENTRY_A, calc_pkg::ENTRY_B: begin
                    if (accept && cmd.is_digit) begin
                        // start pulse lands in the first scale cycle
                        mul_start <= 1'b1;
                        state     <= in_a ? calc_pkg::SCALE_A : calc_pkg::SCALE_B;
                    end else if (accept) begin
                        case (cmd.op)
                            calc_pkg::OP_NEG: begin
                                if (in_a) begin
                                    op_a <= fold(!op_a[WIDTH-1], op_a[MW-1:0]);
                                end else begin
                                    op_b <= fold(!op_b[WIDTH-1], op_b[MW-1:0]);
                                end
                            end
                            calc_pkg::OP_ADD, calc_pkg::OP_SUB, calc_pkg::OP_MUL: begin
                                oper  <= cmd.op;
                                state <= calc_pkg::ENTRY_B;
                            end
                            calc_pkg::OP_EQ: begin
                                // equal without an operator does nothing
                                if (!in_a) begin
                                    state <= calc_pkg::EXECUTE;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                calc_pkg::SCALE_A: begin
                    if (mul_finish) begin
                        op_a  <= mul_out;
                        state <= calc_pkg::ADD_DIGIT_A;
                    end
                end
                calc_pkg::ADD_DIGIT_A: begin
                    op_a  <= fold(op_a[WIDTH-1], op_a[MW-1:0] + MW'(digit_q));
                    state <= calc_pkg::ENTRY_A;
                end
                calc_pkg::SCALE_B: begin
                    if (mul_finish) begin
                        op_b  <= mul_out;
                        state <= calc_pkg::ADD_DIGIT_B;
                    end
                end
                calc_pkg::ADD_DIGIT_B: begin
                    op_b  <= fold(op_b[WIDTH-1], op_b[MW-1:0] + MW'(digit_q));
                    state <= calc_pkg::ENTRY_B;
                end
                calc_pkg::EXECUTE: begin
                    as_start  <= !exec_mul;
                    mul_start <= exec_mul;
                    state     <= calc_pkg::WAIT_EXEC;
                end
                calc_pkg::WAIT_EXEC: begin
                    if (unit_finish) begin
                        done  <= 1'b1;
                        state <= calc_pkg::SHOW;
                    end
                end
                calc_pkg::SHOW: begin
                    result <= exec_mul ? mul_out : as_out;
                    op_a   <= '0;
                    op_b   <= '0;
                    state  <= calc_pkg::ENTRY_A;
                end
                default: state <= calc_pkg::ENTRY_A;
            endcase
        end
    end

    // a key held during a busy state is not taken, operator and pending digit stay put
    a_busy_no_take: assert property (@(posedge clk) disable iff (!nRST)
        busy && cmd.valid |=> $stable(oper) && $stable(digit_q));

    // digit step: launch, WIDTH-1 multiply cycles, digit add, then ready again
    a_digit_time: assert property (@(posedge clk) disable iff (!nRST)
        accept && cmd.is_digit |-> ##(WIDTH+1) !cmd_ready ##1 cmd_ready);

endmodule

/* hw/apb_key_port.sv */
// APB3 slave; KEY and OP are write-only, STATUS and RESULT read-only, others raise PSLVERR
`timescale 1ns/1ps

module apb_key_port #(
    parameter int WIDTH = 16
) (
    input  logic               clk,
    input  logic               nRST,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [3:0]         paddr,
    input  logic [WIDTH-1:0]   pwdata,
    output logic [WIDTH-1:0]   prdata,
    output logic               pready,
    output logic               pslverr,
    output calc_pkg::key_cmd_t cmd,
    input  logic               cmd_ready,
    input  logic               busy,
    input  logic               done,
    input  logic [WIDTH-1:0]   result
);

    logic             setup;
    logic             access;
    logic             key_ok;
    logic             op_ok;
    logic             wr_cmd;
    logic             wr_err;
    logic             rd_err_q;
    logic [WIDTH-1:0] rdata_q;

    assign setup  = psel && !penable;
    assign access = psel && penable;

    // key code checks on the full write word
    assign key_ok = pwdata <= WIDTH'(9);
    assign op_ok  = (pwdata >= WIDTH'(calc_pkg::OP_NEG)) && (pwdata <= WIDTH'(calc_pkg::OP_EQ));
    assign wr_cmd = pwrite && (((paddr == calc_pkg::REG_KEY) && key_ok) ||
                               ((paddr == calc_pkg::REG_OP) && op_ok));
    assign wr_err = pwrite && !wr_cmd;

    assign cmd.valid    = access && wr_cmd;
    assign cmd.is_digit = (paddr == calc_pkg::REG_KEY);
    assign cmd.digit    = pwdata[3:0];
    assign cmd.op       = calc_pkg::key_op_t'(pwdata[2:0]);

    // key writes wait for the controller, everything else completes at once
    assign pready  = access && (!wr_cmd || cmd_ready);
    assign pslverr = access && (pwrite ? wr_err : rd_err_q);
    assign prdata  = (access && !pwrite) ? rdata_q : '0;

    // read data captured in the setup phase
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            rdata_q  <= '0;
            rd_err_q <= 1'b0;
        end else if (setup && !pwrite) begin
            case (paddr)
                calc_pkg::REG_STATUS: begin
                    rdata_q  <= {{(WIDTH-2){1'b0}}, done, busy};
                    rd_err_q <= 1'b0;
                end
                calc_pkg::REG_RESULT: begin
                    rdata_q  <= result;
                    rd_err_q <= 1'b0;
                end
                default: begin
                    rdata_q  <= '0;
                    rd_err_q <= 1'b1;
                end
            endcase
        end
    end

    a_err_ready: assert property (@(posedge clk) disable iff (!nRST) pslverr |-> pready);

    // a stalled key must be held by the host until the controller takes it
    a_cmd_hold: assert property (@(posedge clk) disable iff (!nRST)
        cmd.valid && !cmd_ready |=> cmd.valid && $stable(cmd));

endmodule

/* hw/calc_top.sv */
// calculator top level; WIDTH sets the word size, sign bit plus WIDTH-1 magnitude bits
`timescale 1ns/1ps

module calc_top #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [3:0]       paddr,
    input  logic [WIDTH-1:0] pwdata,
    output logic [WIDTH-1:0] prdata,
    output logic             pready,
    output logic             pslverr
);

    calc_pkg::key_cmd_t cmd;
    logic               cmd_ready;
    logic               busy;
    logic               done;
    logic [WIDTH-1:0]   result;
    logic               as_start;
    logic               as_sub;
    logic [WIDTH-1:0]   as_a;
    logic [WIDTH-1:0]   as_b;
    logic [WIDTH-1:0]   as_out;
    logic               as_finish;
    logic               mul_start;
    logic [WIDTH-1:0]   mul_a;
    logic [WIDTH-1:0]   mul_b;
    logic [WIDTH-1:0]   mul_out;
    logic               mul_finish;

    apb_key_port #(.WIDTH(WIDTH)) port_i (
        .clk(clk), .nRST(nRST),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .cmd(cmd), .cmd_ready(cmd_ready),
        .busy(busy), .done(done), .result(result)
    );

    calc_controller #(.WIDTH(WIDTH)) ctrl_i (
        .clk(clk), .nRST(nRST),
        .cmd(cmd), .cmd_ready(cmd_ready),
        .busy(busy), .done(done), .result(result),
        .as_start(as_start), .as_sub(as_sub), .as_a(as_a), .as_b(as_b),
        .as_out(as_out), .as_finish(as_finish),
        .mul_start(mul_start), .mul_a(mul_a), .mul_b(mul_b),
        .mul_out(mul_out), .mul_finish(mul_finish)
    );

    sm_addsub #(.WIDTH(WIDTH)) addsub_i (
        .clk(clk), .nRST(nRST),
        .start(as_start), .sub(as_sub), .a(as_a), .b(as_b),
        .out(as_out), .finish(as_finish)
    );

    seq_multiplier #(.WIDTH(WIDTH)) mul_i (
        .clk(clk), .nRST(nRST),
        .start(mul_start), .a(mul_a), .b(mul_b),
        .out(mul_out), .finish(mul_finish)
    );

endmodule

/* sim/tb_calc.sv */
// testbench for calc_top at WIDTH 16; paddr is 4 bits wide, so offset 0x10 aliases to 0x0
`timescale 1ns/1ps

module tb_calc;

    localparam int WIDTH      = 16;
    localparam int PERIOD     = 20;
    localparam int NROWS      = 15;
    localparam int APB_CYCLES = 8;
    localparam int MAX_CYCLES = NROWS * 8 * (WIDTH + 1 + APB_CYCLES) * 2;
    localparam int MAG_MOD    = 1 << (WIDTH - 1);

    logic             clk;
    logic             nRST;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [3:0]       paddr;
    logic [WIDTH-1:0] pwdata;
    logic [WIDTH-1:0] prdata;
    logic             pready;
    logic             pslverr;

    // one row per calculation, a key is {is_op, code}
    string            row_name [NROWS];
    int               row_len  [NROWS];
    logic [4:0]       row_keys [NROWS][8];
    logic [7:0]       row_err  [NROWS];
    logic [WIDTH-1:0] row_exp  [NROWS];
    int               n_rows;

    logic [31:0] lfsr;
    int          cycles;
    int          errors;
    int          passed;
    int          failed;

    calc_top #(.WIDTH(WIDTH)) calc_top_i (
        .clk(clk), .nRST(nRST),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #(PERIOD/2) clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [4:0] key_digit(input int d);
        return {1'b0, d[3:0]};
    endfunction

    function automatic logic [4:0] key_op(input logic [2:0] code);
        return {2'b10, code};
    endfunction

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic int lfsr_bits(input int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    // reference model on plain integers
    function automatic longint sm_to_int(input logic [WIDTH-1:0] v);
        longint m;
        m = longint'(v[WIDTH-2:0]);
        return v[WIDTH-1] ? -m : m;
    endfunction

    // magnitude wraps, zero is always positive
    function automatic logic [WIDTH-1:0] int_to_sm(input longint r);
        longint           m;
        logic [WIDTH-1:0] v;
        m = (r < 0 ? -r : r) % MAG_MOD;
        if (m == 0) begin
            v = '0;
        end else begin
            v = {r < 0, m[WIDTH-2:0]};
        end
        return v;
    endfunction

    function automatic logic [WIDTH-1:0] enter_digit(input logic [WIDTH-1:0] v, input int d);
        longint m;
        m = (longint'(v[WIDTH-2:0]) * 10 + d) % MAG_MOD;
        return int_to_sm(v[WIDTH-1] ? -m : m);
    endfunction

    function automatic logic [WIDTH-1:0] model_calc(input logic [WIDTH-1:0] a,
                                                    input logic [WIDTH-1:0] b,
                                                    input logic [2:0] code);
        longint r;
        if (code == calc_pkg::OP_SUB) begin
            r = sm_to_int(a) - sm_to_int(b);
        end else if (code == calc_pkg::OP_MUL) begin
            r = sm_to_int(a) * sm_to_int(b);
        end else begin
            r = sm_to_int(a) + sm_to_int(b);
        end
        return int_to_sm(r);
    endfunction

    task automatic add_row(input string name, input int len, input logic [39:0] keys,
                           input logic [7:0] err, input logic [WIDTH-1:0] expv);
        row_name[n_rows] = name;
        row_len[n_rows]  = len;
        row_err[n_rows]  = err;
        row_exp[n_rows]  = expv;
        for (int i = 0; i < 8; i++) begin
            row_keys[n_rows][i] = keys[39 - 5*i -: 5];
        end
        n_rows++;
    endtask

    // three digits, operator, three digits, equal
    task automatic add_random_row(input int idx);
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [4:0]       k [8];
        logic [2:0]       code;
        int               d;
        a = '0;
        b = '0;
        for (int i = 0; i < 3; i++) begin
            d    = lfsr_bits(4) % 10;
            a    = enter_digit(a, d);
            k[i] = key_digit(d);
        end
        code = 3'd2 + 3'(lfsr_bits(2) % 3);
        k[3] = key_op(code);
        for (int i = 0; i < 3; i++) begin
            d        = lfsr_bits(4) % 10;
            b        = enter_digit(b, d);
            k[4 + i] = key_digit(d);
        end
        k[7] = key_op(calc_pkg::OP_EQ);
        add_row($sformatf("random_%0d", idx), 8,
                {k[0], k[1], k[2], k[3], k[4], k[5], k[6], k[7]}, 8'h00, model_calc(a, b, code));
    endtask

    // one APB transfer, inputs change only on the falling edge
    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [WIDTH-1:0] wdata,
                            output logic [WIDTH-1:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        // look a quarter period after the drive edge
        #(PERIOD/4);
        while (!pready) begin
            @(negedge clk);
            #(PERIOD/4);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic wait_idle(output logic [WIDTH-1:0] status);
        logic err;
        status = WIDTH'(1);
        while (status[0]) begin
            apb_xfer(1'b0, calc_pkg::REG_STATUS, '0, status, err);
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            passed++;
            $display("%s: ok", name);
        end else begin
            failed++;
            errors += errs;
            $display("%s: %0d errors", name, errs);
        end
    endtask

    initial begin
        logic [WIDTH-1:0] rdata;
        logic [WIDTH-1:0] status;
        logic             err;
        int               errs;
        clk     = 1'b0;
        nRST    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        lfsr    = 32'h72577cc8;
        cycles  = 0;
        errors  = 0;
        passed  = 0;
        failed  = 0;
        n_rows  = 0;

        add_row("add_multi_digit", 7, {key_digit(1), key_digit(2), key_digit(3),
                key_op(calc_pkg::OP_ADD), key_digit(4), key_digit(5), key_op(calc_pkg::OP_EQ),
                5'd0}, 8'h00, 16'h00A8);
        add_row("sub_across_zero", 6, {key_digit(2), key_digit(5), key_op(calc_pkg::OP_SUB),
                key_digit(4), key_digit(0), key_op(calc_pkg::OP_EQ), 5'd0, 5'd0},
                8'h00, 16'h800F);
        add_row("neg_plus_pos", 5, {key_digit(7), key_op(calc_pkg::OP_NEG),
                key_op(calc_pkg::OP_ADD), key_digit(7), key_op(calc_pkg::OP_EQ), 5'd0, 5'd0,
                5'd0}, 8'h00, 16'h0000);
        add_row("double_negate", 6, {key_digit(4), key_op(calc_pkg::OP_NEG),
                key_op(calc_pkg::OP_NEG), key_op(calc_pkg::OP_SUB), key_digit(1),
                key_op(calc_pkg::OP_EQ), 5'd0, 5'd0}, 8'h00, 16'h0003);
        add_row("mul_two_negatives", 8, {key_digit(1), key_digit(2), key_op(calc_pkg::OP_NEG),
                key_op(calc_pkg::OP_MUL), key_digit(1), key_digit(1), key_op(calc_pkg::OP_NEG),
                key_op(calc_pkg::OP_EQ)}, 8'h00, 16'h0084);
        add_row("mul_neg_by_zero", 5, {key_digit(3), key_op(calc_pkg::OP_NEG),
                key_op(calc_pkg::OP_MUL), key_digit(0), key_op(calc_pkg::OP_EQ), 5'd0, 5'd0,
                5'd0}, 8'h00, 16'h0000);
        // 999999 mod 32768
        add_row("six_nines", 8, {key_digit(9), key_digit(9), key_digit(9), key_digit(9),
                key_digit(9), key_digit(9), key_op(calc_pkg::OP_ADD), key_op(calc_pkg::OP_EQ)},
                8'h00, 16'h423F);
        // 90000 mod 32768
        add_row("mul_truncate", 8, {key_digit(3), key_digit(0), key_digit(0),
                key_op(calc_pkg::OP_MUL), key_digit(3), key_digit(0), key_digit(0),
                key_op(calc_pkg::OP_EQ)}, 8'h00, 16'h5F90);
        add_row("rejected_keys", 7, {key_digit(1), key_digit(2), key_digit(12),
                key_op(calc_pkg::OP_ADD), key_op(3'd7), key_digit(3), key_op(calc_pkg::OP_EQ),
                5'd0}, 8'b0001_0100, 16'h000F);
        add_row("equal_ignored", 5, {key_digit(5), key_op(calc_pkg::OP_EQ),
                key_op(calc_pkg::OP_ADD), key_digit(3), key_op(calc_pkg::OP_EQ), 5'd0, 5'd0,
                5'd0}, 8'h00, 16'h0008);
        add_row("operator_replaced", 5, {key_digit(6), key_op(calc_pkg::OP_ADD),
                key_op(calc_pkg::OP_MUL), key_digit(7), key_op(calc_pkg::OP_EQ), 5'd0, 5'd0,
                5'd0}, 8'h00, 16'h002A);
        for (int i = 0; i < 4; i++) begin
            add_random_row(i);
        end

        repeat (5) @(negedge clk);
        nRST = 1'b1;

        // idle, no result yet
        errs = 0;
        apb_xfer(1'b0, calc_pkg::REG_STATUS, '0, rdata, err);
        if (rdata !== '0) begin
            $display("error: status expected %h got %h", 16'h0000, rdata);
            errs++;
        end
        apb_xfer(1'b0, calc_pkg::REG_RESULT, '0, rdata, err);
        if (rdata !== '0) begin
            $display("error: result expected %h got %h", 16'h0000, rdata);
            errs++;
        end
        report_test("after_reset", errs);

        for (int r = 0; r < n_rows; r++) begin
            errs = 0;
            for (int k = 0; k < row_len[r]; k++) begin
                apb_xfer(1'b1, row_keys[r][k][4] ? calc_pkg::REG_OP : calc_pkg::REG_KEY,
                         WIDTH'(row_keys[r][k][3:0]), rdata, err);
                if (err !== row_err[r][k]) begin
                    $display("error: pslverr on key %0d expected %h got %h",
                             k, row_err[r][k], err);
                    errs++;
                end
            end
            wait_idle(status);
            if (status[1] !== 1'b1) begin
                $display("error: done expected %h got %h", 1'b1, status[1]);
                errs++;
            end
            apb_xfer(1'b0, calc_pkg::REG_RESULT, '0, rdata, err);
            if (rdata !== row_exp[r]) begin
                $display("error: result expected %h got %h", row_exp[r], rdata);
                errs++;
            end
            if (err !== 1'b0) begin
                $display("error: pslverr on result read expected %h got %h", 1'b0, err);
                errs++;
            end
            report_test(row_name[r], errs);
        end

        // 0x2 is unmapped, 0x0 is write only
        errs = 0;
        apb_xfer(1'b0, 4'h2, '0, rdata, err);
        if (err !== 1'b1) begin
            $display("error: pslverr on offset 2 expected %h got %h", 1'b1, err);
            errs++;
        end
        if (rdata !== '0) begin
            $display("error: prdata on offset 2 expected %h got %h", 16'h0000, rdata);
            errs++;
        end
        apb_xfer(1'b0, calc_pkg::REG_KEY, '0, rdata, err);
        if (err !== 1'b1) begin
            $display("error: pslverr on key read expected %h got %h", 1'b1, err);
            errs++;
        end
        report_test("unmapped_read", errs);

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 passed + failed, passed, failed, errors);
        if (failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
hw/calc_pkg.sv
hw/sm_addsub.sv
hw/seq_multiplier.sv
hw/calc_controller.sv
hw/apb_key_port.sv
hw/calc_top.sv
sim/tb_calc.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_calc -f sim.f -o tb_calc_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_calc_sim > sim.log 2>&1
cat sim.log
grep -q "^TB PASSED$" sim.log && exit 0 || exit 1
